// File: design/cacheline_stream.sv
// cacheline word stream
`timescale 1ns/100ps

module cacheline_stream #(
	parameter edge_job_pkg::array_sel_e ARRAY = edge_job_pkg::ARRAY_SRC
) (
	input  logic                     clock,
	input  logic                     rstn,
	input  edge_job_pkg::data_line_t read_data,
	input  logic                     start_shift,
	output edge_job_pkg::word_t      word,
	output logic                     pending,
	output logic                     valid
);

	import edge_job_pkg::*;

	word_t [CL_EDGES-1:0] line;
	logic [OFF_W-1:0]     idx;
	logic [LCNT_W-1:0]    left;
	logic                 load;
	logic                 shift;

	// only lines for this array are taken
	assign load  = read_data.valid && (read_data.array_sel == ARRAY);
	assign shift = start_shift && pending;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			pending <= 1'b0;
			valid   <= 1'b0;
			idx     <= '0;
			left    <= '0;
		end else begin
			valid <= shift;
			if (load) begin
				idx     <= read_data.offset;
				left    <= read_data.count;
				pending <= (read_data.count != '0);
			end else if (shift) begin
				idx  <= idx + 1'b1;
				left <= left - 1'b1;
				// last useful word of the line
				if (left == LCNT_W'(1))
					pending <= 1'b0;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (load)
			line <= read_data.data;
		if (shift)
			word <= line[idx];
	end

	// a new round is issued only after every stream has drained
	a_no_load_pending : assert property (@(posedge clock) disable iff (!rstn)
		load |-> !pending)
		else $error("cacheline_stream: line loaded while pending");

endmodule

// File: design/edge_job_control.sv
// edge job controller top
`timescale 1ns/100ps

module edge_job_control #(
	parameter int CU_ID           = 0,
	parameter int EDGE_FIFO_DEPTH = 16
) (
	input  logic                      clock,
	input  logic                      rstn,
	input  edge_job_pkg::vertex_job_t vertex_job,
	input  edge_job_pkg::wed_t        wed,
	input  edge_job_pkg::data_line_t  read_data,
	input  logic                      cmd_ready,
	input  logic                      edge_request,
	output edge_job_pkg::read_cmd_t   read_cmd,
	output edge_job_pkg::edge_job_t   edge_job,
	output logic                      edge_fifo_empty
);

	import edge_job_pkg::*;

	read_cmd_t            cmd_push;
	logic                 cmd_empty;
	logic                 cmd_pop;
	logic                 start_shift;
	logic                 edge_alfull;
	word_t                src_word;
	word_t                dest_word;
	word_t                weight_word;
	logic                 src_pending;
	logic                 dest_pending;
	logic                 weight_pending;
	logic                 src_valid;
	logic                 dest_valid;
	logic                 weight_valid;
	logic                 any_pending;
	logic                 all_valid;
	logic                 edge_in_flight;
	edge_job_t            edge_q;
	logic [EDGE_ID_W-1:0] edge_id;

	assign any_pending = src_pending || dest_pending || weight_pending;
	assign all_valid   = src_valid && dest_valid && weight_valid;
	// edges between the streams and the FIFO are not yet in its count
	assign edge_in_flight = src_valid || dest_valid || weight_valid || edge_q.valid;
	assign cmd_pop        = cmd_ready && !cmd_empty;

	edge_read_sequencer #(
		.CU_ID(CU_ID)
	) u_sequencer (
		.clock           (clock),
		.rstn            (rstn),
		.vertex_job      (vertex_job),
		.wed             (wed),
		.read_data_valid (read_data.valid),
		.cmd_fifo_empty  (cmd_empty),
		.edge_fifo_alfull(edge_alfull || edge_in_flight),
		.streams_pending (any_pending),
		.cmd_push        (cmd_push),
		.start_shift     (start_shift)
	);

	////////////////////
	// cacheline streams
	////////////////////

	cacheline_stream #(.ARRAY(ARRAY_SRC)) u_src_stream (
		.clock      (clock),
		.rstn       (rstn),
		.read_data  (read_data),
		.start_shift(start_shift),
		.word       (src_word),
		.pending    (src_pending),
		.valid      (src_valid)
	);

	cacheline_stream #(.ARRAY(ARRAY_DEST)) u_dest_stream (
		.clock      (clock),
		.rstn       (rstn),
		.read_data  (read_data),
		.start_shift(start_shift),
		.word       (dest_word),
		.pending    (dest_pending),
		.valid      (dest_valid)
	);

	cacheline_stream #(.ARRAY(ARRAY_WEIGHT)) u_weight_stream (
		.clock      (clock),
		.rstn       (rstn),
		.read_data  (read_data),
		.start_shift(start_shift),
		.word       (weight_word),
		.pending    (weight_pending),
		.valid      (weight_valid)
	);

	////////////////////
	// edge assembly
	////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			edge_q  <= '0;
			edge_id <= '0;
		end else if (all_valid) begin
			edge_q  <= '{valid: 1'b1, id: edge_id, src: src_word,
				dest: dest_word, weight: weight_word};
			edge_id <= edge_id + 1'b1;
		end else begin
			edge_q.valid <= 1'b0;
		end
	end

	sync_fifo #(
		.WIDTH      ($bits(edge_job_t)),
		.DEPTH      (EDGE_FIFO_DEPTH),
		.ALFULL_FREE(CL_EDGES)
	) u_edge_fifo (
		.clock   (clock),
		.rstn    (rstn),
		.push    (edge_q.valid),
		.data_in (edge_q),
		.pop     (edge_request),
		.data_out(edge_job),
		.full    (),
		.alfull  (edge_alfull),
		.empty   (edge_fifo_empty)
	);

	// holds one round of three commands
	sync_fifo #(
		.WIDTH      ($bits(read_cmd_t)),
		.DEPTH      (4),
		.ALFULL_FREE(1)
	) u_cmd_fifo (
		.clock   (clock),
		.rstn    (rstn),
		.push    (cmd_push.valid),
		.data_in (cmd_push),
		.pop     (cmd_pop),
		.data_out(read_cmd),
		.full    (),
		.alfull  (),
		.empty   (cmd_empty)
	);

endmodule

// File: design/edge_job_pkg.sv
// edge job shared types

package edge_job_pkg;

	////////////////////
	// widths and sizes
	////////////////////

	localparam int ADDR_W     = 32;
	localparam int WORD_W     = 32;
	localparam int EDGE_BYTES = 4;
	localparam int CL_BYTES   = 16;
	localparam int CL_EDGES   = CL_BYTES / EDGE_BYTES;
	localparam int CNT_W      = 16;
	localparam int EDGE_ID_W  = 16;

	// derived field widths
	localparam int OFF_W   = $clog2(CL_EDGES);
	localparam int LCNT_W  = $clog2(CL_EDGES + 1);
	localparam int SIZE_W  = 12;
	localparam int CU_ID_W = 8;

	typedef logic [WORD_W-1:0] word_t;

	typedef enum logic [1:0] {
		ARRAY_SRC,
		ARRAY_DEST,
		ARRAY_WEIGHT
	} array_sel_e;

	typedef enum logic [2:0] {
		SEQ_RESET,
		SEQ_INIT,
		SEQ_WAIT,
		SEQ_CALC,
		SEQ_IDLE,
		SEQ_SRC,
		SEQ_DEST,
		SEQ_WEIGHT
	} seq_state_e;

	////////////////////
	// bundles
	////////////////////

	typedef struct packed {
		logic             valid;
		logic [CNT_W-1:0] id;
		logic [CNT_W-1:0] edges_idx;
		logic [CNT_W-1:0] degree;
	} vertex_job_t;

	typedef struct packed {
		logic              valid;
		logic [ADDR_W-1:0] src_base;
		logic [ADDR_W-1:0] dest_base;
		logic [ADDR_W-1:0] weight_base;
	} wed_t;

	typedef struct packed {
		logic               valid;
		array_sel_e         array_sel;
		logic [ADDR_W-1:0]  address;
		logic [SIZE_W-1:0]  size;
		logic [CU_ID_W-1:0] cu_id;
		logic [OFF_W-1:0]   offset;
		logic [LCNT_W-1:0]  count;
	} read_cmd_t;

	typedef struct packed {
		logic                 valid;
		array_sel_e           array_sel;
		logic [OFF_W-1:0]     offset;
		logic [LCNT_W-1:0]    count;
		word_t [CL_EDGES-1:0] data;
	} data_line_t;

	typedef struct packed {
		logic                 valid;
		logic [EDGE_ID_W-1:0] id;
		word_t                src;
		word_t                dest;
		word_t                weight;
	} edge_job_t;

	// power of two covering count elements, at most one cacheline
	function automatic logic [SIZE_W-1:0] request_size(input logic [CNT_W-1:0] count);
		logic [SIZE_W-1:0] size;
		int                bytes;
		bytes = int'(count) * EDGE_BYTES;
		size  = SIZE_W'(1);
		for (int i = 0; i < $clog2(CL_BYTES); i++) begin
			if (int'(size) < bytes)
				size = size << 1;
		end
		return size;
	endfunction

endpackage

// File: design/edge_read_sequencer.sv
// edge read sequencer
`timescale 1ns/100ps

module edge_read_sequencer #(
	parameter int CU_ID = 0
) (
	input  logic                      clock,
	input  logic                      rstn,
	input  edge_job_pkg::vertex_job_t vertex_job,
	input  edge_job_pkg::wed_t        wed,
	input  logic                      read_data_valid,
	input  logic                      cmd_fifo_empty,
	input  logic                      edge_fifo_alfull,
	input  logic                      streams_pending,
	output edge_job_pkg::read_cmd_t   cmd_push,
	output logic                      start_shift
);

	import edge_job_pkg::*;

	localparam int CL_SHIFT   = $clog2(CL_BYTES);
	localparam int EDGE_SHIFT = $clog2(EDGE_BYTES);

	seq_state_e state;
	seq_state_e next_state;

	vertex_job_t         vertex_q;
	logic                new_vertex;
	logic                done;
	logic                accept;
	logic                send_ready;
	logic [CNT_W-1:0]    remaining;
	logic [2:0]          outstanding;
	logic [ADDR_W-1:0]   byte_offset;
	logic [ADDR_W-1:0]   aligned;
	logic [CL_SHIFT-1:0] remainder;
	logic [LCNT_W-1:0]   line_room;
	logic [LCNT_W-1:0]   take;
	logic [SIZE_W-1:0]   req_size;
	logic [OFF_W-1:0]    req_offset;
	logic [LCNT_W-1:0]   req_count;

	////////////////////
	// vertex acceptance
	////////////////////

	// a held vertex is taken again only under a new id
	assign accept = done && vertex_job.valid &&
		(!vertex_q.valid || (vertex_q.id != vertex_job.id));

	assign send_ready = cmd_fifo_empty && !streams_pending && (outstanding == '0) &&
		!edge_fifo_alfull && (remaining != '0);

	assign start_shift = streams_pending && (outstanding == '0);

	// words left before the cacheline boundary
	assign line_room = LCNT_W'((CL_BYTES - int'(remainder)) >> EDGE_SHIFT);
	assign take      = (remaining < CNT_W'(line_room)) ? LCNT_W'(remaining) : line_room;

	////////////////////
	// command FSM
	////////////////////

	always_comb begin
		next_state = state;
		case (state)
			SEQ_RESET  : if (wed.valid) next_state = SEQ_INIT;
			SEQ_INIT   : if (new_vertex && (vertex_q.degree != '0)) next_state = SEQ_WAIT;
			SEQ_WAIT   : if (send_ready) next_state = SEQ_CALC;
			SEQ_CALC   : next_state = SEQ_IDLE;
			SEQ_IDLE   : next_state = SEQ_SRC;
			SEQ_SRC    : next_state = SEQ_DEST;
			SEQ_DEST   : next_state = SEQ_WEIGHT;
			SEQ_WEIGHT : next_state = (remaining != '0) ? SEQ_WAIT : SEQ_INIT;
			default    : next_state = SEQ_RESET;
		endcase
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			state       <= SEQ_RESET;
			vertex_q    <= '0;
			new_vertex  <= 1'b0;
			done        <= 1'b1;
			remaining   <= '0;
			outstanding <= '0;
		end else begin
			state       <= next_state;
			outstanding <= outstanding + 3'(cmd_push.valid) - 3'(read_data_valid);
			case (state)
				SEQ_INIT : begin
					if (new_vertex) begin
						new_vertex <= 1'b0;
						remaining  <= vertex_q.degree;
						done       <= (vertex_q.degree == '0);
					end
				end
				SEQ_CALC   : remaining <= remaining - CNT_W'(take);
				SEQ_WEIGHT : if (remaining == '0) done <= 1'b1;
				default    : ;
			endcase
			if (accept) begin
				vertex_q   <= vertex_job;
				new_vertex <= 1'b1;
				done       <= 1'b0;
			end
		end
	end

	// address and size of the current round
	always_ff @(posedge clock) begin
		case (state)
			SEQ_INIT : begin
				if (new_vertex)
					byte_offset <= ADDR_W'(vertex_q.edges_idx) << EDGE_SHIFT;
			end
			SEQ_WAIT : begin
				remainder <= byte_offset[CL_SHIFT-1:0];
				aligned   <= {byte_offset[ADDR_W-1:CL_SHIFT], {CL_SHIFT{1'b0}}};
			end
			SEQ_CALC : begin
				// misaligned start pulls in the whole line
				req_size   <= (remainder != '0) ? SIZE_W'(CL_BYTES) : request_size(remaining);
				req_count  <= take;
				req_offset <= OFF_W'(remainder >> EDGE_SHIFT);
			end
			SEQ_WEIGHT : byte_offset <= aligned + ADDR_W'(CL_BYTES);
			default    : ;
		endcase
	end

	always_comb begin
		cmd_push        = '0;
		cmd_push.size   = req_size;
		cmd_push.cu_id  = CU_ID_W'(CU_ID);
		cmd_push.offset = req_offset;
		cmd_push.count  = req_count;
		case (state)
			SEQ_SRC : begin
				cmd_push.valid     = 1'b1;
				cmd_push.array_sel = ARRAY_SRC;
				cmd_push.address   = wed.src_base + aligned;
			end
			SEQ_DEST : begin
				cmd_push.valid     = 1'b1;
				cmd_push.array_sel = ARRAY_DEST;
				cmd_push.address   = wed.dest_base + aligned;
			end
			SEQ_WEIGHT : begin
				cmd_push.valid     = 1'b1;
				cmd_push.array_sel = ARRAY_WEIGHT;
				cmd_push.address   = wed.weight_base + aligned;
			end
			default : ;
		endcase
	end

	// memory returns only what was asked for
	a_no_underflow : assert property (@(posedge clock) disable iff (!rstn)
		read_data_valid |-> (outstanding != '0))
		else $error("edge_read_sequencer: response with nothing outstanding");

	// every code of the state register is a named state
	a_state_range : assert property (@(posedge clock) disable iff (!rstn)
		!$isunknown(state))
		else $error("edge_read_sequencer: state out of range");

endmodule

// File: design/sync_fifo.sv
// synchronous FIFO
`timescale 1ns/100ps

module sync_fifo #(
	parameter int WIDTH       = 8,
	parameter int DEPTH       = 4,
	parameter int ALFULL_FREE = 1
) (
	input  logic             clock,
	input  logic             rstn,
	input  logic             push,
	input  logic [WIDTH-1:0] data_in,
	input  logic             pop,
	output logic [WIDTH-1:0] data_out,
	output logic             full,
	output logic             alfull,
	output logic             empty
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

	logic [WIDTH-1:0] mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W:0]   count;
	logic             do_push;
	logic             do_pop;

	assign do_push = push && !full;
	assign do_pop  = pop && !empty;
	assign full    = (int'(count) == DEPTH);
	assign empty   = (count == '0);
	assign alfull  = (DEPTH - int'(count)) < ALFULL_FREE;

	always_ff @(posedge clock) begin
		if (do_push)
			mem[wr_ptr] <= data_in;
	end

	// output word is zero between pops, so its valid bit reads as a strobe
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr   <= '0;
			rd_ptr   <= '0;
			count    <= '0;
			data_out <= '0;
		end else begin
			if (do_push)
				wr_ptr <= (int'(wr_ptr) == DEPTH - 1) ? '0 : wr_ptr + 1'b1;
			if (do_pop) begin
				rd_ptr   <= (int'(rd_ptr) == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
				data_out <= mem[rd_ptr];
			end else begin
				data_out <= '0;
			end
			count <= count + (PTR_W+1)'(do_push) - (PTR_W+1)'(do_pop);
		end
	end

	// writers are expected to check free space before pushing
	a_no_push_full : assert property (@(posedge clock) disable iff (!rstn) push |-> !full)
		else $error("sync_fifo: push while full");

	a_no_pop_empty : assert property (@(posedge clock) disable iff (!rstn) pop |-> !empty)
		else $error("sync_fifo: pop while empty");

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the edge job controller testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
	-f sources.f --top-module tb_edge_job_control -o tb_edge_job_control

./obj_dir/tb_edge_job_control | tee "$LOG"

if grep -q "Some tests failed" "$LOG"; then
	echo "simulation reported errors"
	exit 1
fi
echo "simulation finished without errors"

// File: sources.f
design/edge_job_pkg.sv
design/sync_fifo.sv
design/edge_read_sequencer.sv
design/cacheline_stream.sv
design/edge_job_control.sv
test/tb_edge_job_control.sv

// File: test/tb_edge_job_control.sv
// edge job controller testbench
`timescale 1ns/100ps

module tb_edge_job_control;

	import edge_job_pkg::*;

	localparam int CU_ID      = 5;
	localparam int N_RANDOM   = 10;
	localparam int N_MISALIGN = 6;
	localparam int N_STALL    = 6;
	localparam int N_VERTEX   = N_RANDOM + N_MISALIGN + N_STALL;

	logic        clock;
	logic        rstn;
	vertex_job_t vertex_job;
	wed_t        wed;
	data_line_t  read_data;
	logic        cmd_ready;
	logic        edge_request;
	read_cmd_t   read_cmd;
	edge_job_t   edge_job;
	logic        edge_fifo_empty;

	int                   errors = 0;
	int                   cycle = 0;
	int                   watchdog_cycles = 0;
	int                   tests_run = 0;
	int                   tests_bad = 0;
	bit                   stall_mode = 1'b0;
	int                   idx_list [N_VERTEX];
	int                   deg_list [N_VERTEX];
	edge_job_t            exp_edges [$];
	read_cmd_t            mem_cmds [$];
	int                   mem_due [$];
	int                   last_due = 0;
	logic [EDGE_ID_W-1:0] next_id = '0;

	// command tracking for the vertex in flight
	int                cur_idx;
	int                cur_deg;
	int                src_sum;
	bit                first_src;
	int                grp_pos = 0;
	read_cmd_t         grp_head;
	logic [ADDR_W-1:0] grp_rel;

	edge_job_control #(
		.CU_ID          (CU_ID),
		.EDGE_FIFO_DEPTH(16)
	) u_dut (
		.clock          (clock),
		.rstn           (rstn),
		.vertex_job     (vertex_job),
		.wed            (wed),
		.read_data      (read_data),
		.cmd_ready      (cmd_ready),
		.edge_request   (edge_request),
		.read_cmd       (read_cmd),
		.edge_job       (edge_job),
		.edge_fifo_empty(edge_fifo_empty)
	);

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	always @(posedge clock)
		cycle <= cycle + 1;

	////////////////////
	// reference model
	////////////////////

	// memory contents as a function of byte address and array
	function automatic word_t mem_word(input logic [ADDR_W-1:0] addr, input array_sel_e arr);
		return addr * 32'd3 + 32'(arr) * 32'h1000_0000 + 32'd1;
	endfunction

	function automatic logic [ADDR_W-1:0] base_of(input array_sel_e arr);
		case (arr)
			ARRAY_SRC  : return wed.src_base;
			ARRAY_DEST : return wed.dest_base;
			default    : return wed.weight_base;
		endcase
	endfunction

	task automatic check_hex(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp) else begin
			$display("Fail %s: got %h expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic check_cmd(input read_cmd_t cmd);
		logic [ADDR_W-1:0] rel;
		int                exp_count;
		rel = cmd.address - base_of(cmd.array_sel);
		assert ((cmd.address & ADDR_W'(CL_BYTES - 1)) == '0) else begin
			$display("Fail read_cmd.address: %h not aligned to a cacheline", cmd.address);
			errors++;
		end
		assert (cmd.size != '0 && (cmd.size & (cmd.size - 1'b1)) == '0 &&
			int'(cmd.size) <= CL_BYTES && int'(cmd.size) >= int'(cmd.count) * EDGE_BYTES) else begin
			$display("Fail read_cmd.size: %h for count %h", cmd.size, cmd.count);
			errors++;
		end
		assert (int'(cmd.count) <= CL_EDGES && int'(cmd.offset) + int'(cmd.count) <= CL_EDGES)
		else begin
			$display("Fail read_cmd.count: %h with offset %h", cmd.count, cmd.offset);
			errors++;
		end
		check_hex("read_cmd.cu_id", 32'(cmd.cu_id), 32'(CU_ID));
		check_hex("read_cmd.array_sel", 32'(cmd.array_sel), 32'(grp_pos));
		// dest and weight repeat the shape of the src command
		if (grp_pos == 0) begin
			grp_head = cmd;
			grp_rel  = rel;
		end else begin
			check_hex("read_cmd.offset", 32'(cmd.offset), 32'(grp_head.offset));
			check_hex("read_cmd.count", 32'(cmd.count), 32'(grp_head.count));
			check_hex("read_cmd.size", 32'(cmd.size), 32'(grp_head.size));
			check_hex("read_cmd.address offset", rel, grp_rel);
		end
		if (cmd.array_sel == ARRAY_SRC) begin
			src_sum += int'(cmd.count);
			if (first_src) begin
				first_src = 1'b0;
				check_hex("read_cmd.offset", 32'(cmd.offset), 32'(cur_idx % CL_EDGES));
				if (cur_idx % CL_EDGES != 0) begin
					exp_count = CL_EDGES - cur_idx % CL_EDGES;
					if (exp_count > cur_deg)
						exp_count = cur_deg;
					check_hex("read_cmd.size", 32'(cmd.size), 32'(CL_BYTES));
					check_hex("read_cmd.count", 32'(cmd.count), 32'(exp_count));
				end
			end
		end
		grp_pos = (grp_pos + 1) % 3;
	endtask

	////////////////////
	// memory responder
	////////////////////

	always @(negedge clock) begin
		int due;
		if (rstn && read_cmd.valid) begin
			check_cmd(read_cmd);
			due = cycle + 1 + int'($urandom % 6);
			// one line per cycle, in command order
			if (due <= last_due)
				due = last_due + 1;
			last_due = due;
			mem_cmds.push_back(read_cmd);
			mem_due.push_back(due);
		end
	end

	always @(negedge clock) begin
		edge_job_t exp;
		if (rstn && edge_job.valid) begin
			assert (exp_edges.size() != 0) else begin
				$display("edge with id %h arrived when no edge was expected", edge_job.id);
				errors++;
			end
			if (exp_edges.size() != 0) begin
				exp = exp_edges.pop_front();
				check_hex("edge_job.id", 32'(edge_job.id), 32'(exp.id));
				check_hex("edge_job.src", edge_job.src, exp.src);
				check_hex("edge_job.dest", edge_job.dest, exp.dest);
				check_hex("edge_job.weight", edge_job.weight, exp.weight);
			end
		end
		// edges held in the FIFO are still to come
		if (rstn && !edge_fifo_empty) begin
			assert (exp_edges.size() != 0) else begin
				$display("edge FIFO reports edges when none are left to come");
				errors++;
			end
		end
	end

	// memory lines, command back-pressure and edge pops
	initial begin
		read_cmd_t cmd;
		int        cmd_left;
		int        req_left;
		bit        cmd_level;
		bit        req_level;
		cmd_left = 0;
		req_left = 0;
		cmd_level = 1'b1;
		req_level = 1'b1;
		forever begin
			@(posedge clock);
			#1;
			read_data = '0;
			if (mem_cmds.size() != 0 && mem_due[0] <= cycle) begin
				cmd = mem_cmds.pop_front();
				void'(mem_due.pop_front());
				read_data.valid     = 1'b1;
				read_data.array_sel = cmd.array_sel;
				read_data.offset    = cmd.offset;
				read_data.count     = cmd.count;
				for (int i = 0; i < CL_EDGES; i++)
					read_data.data[i] = mem_word(cmd.address + ADDR_W'(i * EDGE_BYTES),
						cmd.array_sel);
			end
			if (stall_mode) begin
				// mostly stalled for long stretches
				if (cmd_left == 0) begin
					cmd_level = ($urandom % 4 == 0);
					cmd_left  = 10 + int'($urandom % 40);
				end
				if (req_left == 0) begin
					req_level = ($urandom % 10 < 3);
					req_left  = 10 + int'($urandom % 50);
				end
				cmd_left--;
				req_left--;
			end else begin
				cmd_level = ($urandom % 4 != 0);
				req_level = 1'b1;
			end
			cmd_ready    = cmd_level;
			edge_request = req_level && !edge_fifo_empty && ($urandom % 2 == 0);
		end
	end

	////////////////////
	// tests
	////////////////////

	task automatic run_vertex(input int v);
		edge_job_t e;
		cur_idx   = idx_list[v];
		cur_deg   = deg_list[v];
		src_sum   = 0;
		first_src = 1'b1;
		for (int k = 0; k < cur_deg; k++) begin
			e.valid  = 1'b1;
			e.id     = next_id;
			e.src    = mem_word(wed.src_base + ADDR_W'((cur_idx + k) * EDGE_BYTES), ARRAY_SRC);
			e.dest   = mem_word(wed.dest_base + ADDR_W'((cur_idx + k) * EDGE_BYTES), ARRAY_DEST);
			e.weight = mem_word(wed.weight_base + ADDR_W'((cur_idx + k) * EDGE_BYTES),
				ARRAY_WEIGHT);
			exp_edges.push_back(e);
			next_id++;
		end
		@(posedge clock);
		#1;
		vertex_job = '{valid: 1'b1, id: CNT_W'(v + 1), edges_idx: CNT_W'(cur_idx),
			degree: CNT_W'(cur_deg)};
		while (exp_edges.size() != 0)
			@(posedge clock);
		check_hex("src command count total", 32'(src_sum), 32'(cur_deg));
		check_hex("command group position", 32'(grp_pos), 32'd0);
	endtask

	task automatic run_test(input string name, input int first, input int n, input bit stall);
		int start_errors;
		start_errors = errors;
		stall_mode   = stall;
		for (int v = first; v < first + n; v++)
			run_vertex(v);
		stall_mode = 1'b0;
		tests_run++;
		if (errors != start_errors)
			tests_bad++;
		$display("test %-18s %0d vertices, %0d errors", name, n, errors - start_errors);
	endtask

	initial begin
		int total;
		void'($urandom(32'h841e_3c22));
		rstn         = 1'b0;
		vertex_job   = '0;
		wed          = '0;
		read_data    = '0;
		cmd_ready    = 1'b0;
		edge_request = 1'b0;
		total        = 0;
		for (int v = 0; v < N_VERTEX; v++) begin
			if (v >= N_RANDOM && v < N_RANDOM + N_MISALIGN)
				idx_list[v] = 4 * int'($urandom % 50) + 1 + int'($urandom % 3);
			else
				idx_list[v] = int'($urandom % 201);
			deg_list[v] = 1 + int'($urandom % 20);
			total += deg_list[v];
		end
		watchdog_cycles = 200 * total + 1000;
		repeat (4) @(posedge clock);
		#1;
		rstn = 1'b1;
		@(posedge clock);
		#1;
		// cacheline aligned bases
		wed = '{valid: 1'b1, src_base: $urandom & 32'h00ff_fff0,
			dest_base: 32'h0100_0000 | ($urandom & 32'h00ff_fff0),
			weight_base: 32'h0200_0000 | ($urandom & 32'h00ff_fff0)};
		run_test("random vertices", 0, N_RANDOM, 1'b0);
		run_test("misaligned starts", N_RANDOM, N_MISALIGN, 1'b0);
		run_test("back-pressure", N_RANDOM + N_MISALIGN, N_STALL, 1'b1);
		// late duplicates would show up here
		repeat (50) @(posedge clock);
		assert (exp_edges.size() == 0 && mem_cmds.size() == 0 && edge_fifo_empty) else begin
			$display("work left over at the end of the run");
			errors++;
		end
		$display("tests run %0d, tests with errors %0d, failed checks %0d",
			tests_run, tests_bad, errors);
		if (errors == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

	initial begin
		wait (watchdog_cycles != 0);
		repeat (watchdog_cycles) @(posedge clock);
		$display("timeout after %0d cycles with %0d edges still expected",
			watchdog_cycles, exp_edges.size());
		$display("Some tests failed");
		$finish;
	end

endmodule
